// File: fill_peak_tracker.sv
`timescale 1ns/10ps
`include "stats_cfg.svh"

module fill_peak_tracker #(
    parameter int N_CH = `N_FILL
) (
    input  logic                     clk_pkt,
    input  logic                     rst_pkt,
    input  pkt_meta_pkg::fill_vec_t  fill_level_i,
    output stats_reg_pkg::peak_vec_t peak_o
);
    import stats_reg_pkg::*;

    peak_vec_t fill_ext;

    // widen each level to a counter word
    always_comb begin
        fill_ext = '0;
        for (int ch = 0; ch < N_CH; ch++) begin
            fill_ext[ch] = {{(`STAT_W-`FILL_W){1'b0}}, fill_level_i[ch]};
        end
    end

    always_ff @(posedge clk_pkt) begin
        if (rst_pkt) begin
            peak_o <= '0;
        end else begin
            for (int ch = 0; ch < N_CH; ch++) begin
                if (fill_ext[ch] > peak_o[ch]) begin
                    peak_o[ch] <= fill_ext[ch];
                end
            end
        end
    end

    for (genvar ch = 0; ch < N_CH; ch++) begin : g_hold
        peak_hold_a: assert property (
            @(posedge clk_pkt) disable iff (rst_pkt)
            !$past(rst_pkt) |-> peak_o[ch] >= $past(peak_o[ch])
        );
    end

endmodule

// File: pkt_event_counter.sv
`timescale 1ns/10ps

module pkt_event_counter (
    input  logic                      clk_pkt,
    input  logic                      rst_pkt,
    input  pkt_meta_pkg::pkt_mark_t   in_mark_i,
    input  pkt_meta_pkg::pkt_mark_t   out_mark_i,
    input  logic                      out_ready_i,
    input  logic                      rb_update_valid_i,
    input  logic                      disable_pcie_i,
    input  pkt_meta_pkg::pdu_meta_t   pdumeta_cpu_data_i,
    input  logic                      pdumeta_cpu_valid_i,
    input  logic                      pdumeta_cpu_ready_i,
    output logic                      pcie_rb_update_valid_o,
    output stats_reg_pkg::evt_count_t evt_count_o
);
    import pkt_meta_pkg::*;

    logic in_done;
    logic out_done;
    logic cpu_accept;

    // a packet counts once, on its last beat
    assign in_done    = in_mark_i.valid & in_mark_i.eop;
    assign out_done   = out_mark_i.valid & out_mark_i.eop & out_ready_i;
    assign cpu_accept = pdumeta_cpu_valid_i & pdumeta_cpu_ready_i;

    // ring-buffer updates never reach pcie while it is off
    assign pcie_rb_update_valid_o = rb_update_valid_i & ~disable_pcie_i;

    always_ff @(posedge clk_pkt) begin
        if (rst_pkt) begin
            evt_count_o <= '0;
        end else begin
            if (in_done) begin
                evt_count_o.in_pkt <= evt_count_o.in_pkt + 1'b1;
            end
            if (out_done) begin
                evt_count_o.out_pkt <= evt_count_o.out_pkt + 1'b1;
            end
            // dma count sees every update, gated or not
            if (rb_update_valid_i) begin
                evt_count_o.dma_pkt <= evt_count_o.dma_pkt + 1'b1;
            end
            if (cpu_accept) begin
                case (pdumeta_cpu_data_i.action)
                    ACTION_NOMATCH: begin
                        evt_count_o.cpu_nomatch_pkt <= evt_count_o.cpu_nomatch_pkt + 1'b1;
                    end
                    ACTION_MATCH: begin
                        evt_count_o.cpu_match_pkt <= evt_count_o.cpu_match_pkt + 1'b1;
                    end
                    // drop and forward records are not counted here
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: pkt_meta_pkg.sv
`include "stats_cfg.svh"

package pkt_meta_pkg;

    // beat markers of one stream beat
    typedef struct packed {
        logic valid;
        logic sop;
        logic eop;
    } pkt_mark_t;

    // verdict carried with each cpu metadata record
    typedef enum logic [3:0] {
        ACTION_NOMATCH = 4'd0,
        ACTION_MATCH   = 4'd1,
        ACTION_DROP    = 4'd2,
        ACTION_FORWARD = 4'd3
    } pdu_action_e;

    typedef struct packed {
        pdu_action_e action;
        logic [23:0] tag;
    } pdu_meta_t;

    // one level per tracked channel fifo
    // order: dm2sm, sm2pg, pg2nf, nf2pdu
    typedef logic [`N_FILL-1:0][`FILL_W-1:0] fill_vec_t;

endpackage

// File: sources.f
+incdir+.
pkt_meta_pkg.sv
stats_reg_pkg.sv
pkt_event_counter.sv
fill_peak_tracker.sv
status_sync.sv
status_csr.sv
stats_top.sv
tb_stats_top.sv

// File: stats_cfg.svh
`ifndef STATS_CFG_SVH
`define STATS_CFG_SVH

// counter and fill widths
`define STAT_W 32
`define FILL_W 16
`define N_FILL 4

// status address layout
`define STAT_OFS_W 8
`define STAT_SEL_W 4
`define STAT_ADDR_W 30

// block select of this register bank
`define TOP_SEL `STAT_SEL_W'(0)

// returned for offsets with no register behind them
`define STAT_BAD_WORD 32'hDEADBEEF

// register ranks on the way into clk_status
`define SYNC_STAGES 2

`endif

// File: stats_reg_pkg.sv
`include "stats_cfg.svh"

package stats_reg_pkg;

    // register offsets within the top block
    typedef enum logic [`STAT_OFS_W-1:0] {
        REG_IN_PKT          = 8'd0,
        REG_OUT_PKT         = 8'd1,
        REG_DMA_PKT         = 8'd2,
        REG_CPU_NOMATCH_PKT = 8'd3,
        REG_CPU_MATCH_PKT   = 8'd4,
        REG_CTRL            = 8'd5,
        REG_MAX_DM2SM       = 8'd6,
        REG_MAX_SM2PG       = 8'd7,
        REG_MAX_PG2NF       = 8'd8,
        REG_MAX_NF2PDU      = 8'd9
    } stat_reg_e;

    typedef struct packed {
        logic [`STAT_SEL_W-1:0]                          sel;
        logic [`STAT_ADDR_W-`STAT_SEL_W-`STAT_OFS_W-1:0] rsvd;
        logic [`STAT_OFS_W-1:0]                          ofs;
    } status_addr_t;

    typedef struct packed {
        logic               read;
        logic               write;
        status_addr_t       addr;
        logic [`STAT_W-1:0] writedata;
    } status_req_t;

    typedef struct packed {
        logic               valid;
        logic [`STAT_W-1:0] readdata;
    } status_resp_t;

    typedef struct packed {
        logic [`STAT_W-1:0] in_pkt;
        logic [`STAT_W-1:0] out_pkt;
        logic [`STAT_W-1:0] dma_pkt;
        logic [`STAT_W-1:0] cpu_nomatch_pkt;
        logic [`STAT_W-1:0] cpu_match_pkt;
    } evt_count_t;

    typedef logic [`N_FILL-1:0][`STAT_W-1:0] peak_vec_t;

    // everything the status port can read, in one word
    typedef struct packed {
        evt_count_t evt;
        peak_vec_t  peak;
    } stat_snapshot_t;

endpackage

// File: stats_top.sv
`timescale 1ns/10ps
`include "stats_cfg.svh"

module stats_top (
    input  logic                        clk_pkt,
    input  logic                        rst_pkt,
    input  logic                        clk_status,
    input  logic                        rst,
    input  pkt_meta_pkg::pkt_mark_t     in_mark_i,
    input  pkt_meta_pkg::pkt_mark_t     out_mark_i,
    input  logic                        out_ready_i,
    input  logic                        rb_update_valid_i,
    input  logic                        disable_pcie_i,
    output logic                        pcie_rb_update_valid_o,
    input  pkt_meta_pkg::pdu_meta_t     pdumeta_cpu_data_i,
    input  logic                        pdumeta_cpu_valid_i,
    input  logic                        pdumeta_cpu_ready_i,
    input  pkt_meta_pkg::fill_vec_t     fill_level_i,
    input  stats_reg_pkg::status_req_t  status_req_i,
    output stats_reg_pkg::status_resp_t status_resp_o,
    output logic [`STAT_W-1:0]          ctrl_o
);
    import stats_reg_pkg::*;

    evt_count_t     evt_count;
    peak_vec_t      peak;
    stat_snapshot_t snapshot;

    // clk_pkt domain
    pkt_event_counter evt_cnt_i (
        .clk_pkt                (clk_pkt),
        .rst_pkt                (rst_pkt),
        .in_mark_i              (in_mark_i),
        .out_mark_i             (out_mark_i),
        .out_ready_i            (out_ready_i),
        .rb_update_valid_i      (rb_update_valid_i),
        .disable_pcie_i         (disable_pcie_i),
        .pdumeta_cpu_data_i     (pdumeta_cpu_data_i),
        .pdumeta_cpu_valid_i    (pdumeta_cpu_valid_i),
        .pdumeta_cpu_ready_i    (pdumeta_cpu_ready_i),
        .pcie_rb_update_valid_o (pcie_rb_update_valid_o),
        .evt_count_o            (evt_count)
    );

    fill_peak_tracker #(.N_CH(`N_FILL)) peak_i (
        .clk_pkt      (clk_pkt),
        .rst_pkt      (rst_pkt),
        .fill_level_i (fill_level_i),
        .peak_o       (peak)
    );

    // into clk_status
    status_sync #(.STAGES(`SYNC_STAGES)) sync_i (
        .clk_status  (clk_status),
        .evt_count_i (evt_count),
        .peak_i      (peak),
        .snapshot_o  (snapshot)
    );

    status_csr csr_i (
        .clk_status    (clk_status),
        .rst           (rst),
        .status_req_i  (status_req_i),
        .snapshot_i    (snapshot),
        .status_resp_o (status_resp_o),
        .ctrl_o        (ctrl_o)
    );

endmodule

// File: status_csr.sv
`timescale 1ns/10ps
`include "stats_cfg.svh"

module status_csr (
    input  logic                          clk_status,
    input  logic                          rst,
    input  stats_reg_pkg::status_req_t    status_req_i,
    input  stats_reg_pkg::stat_snapshot_t snapshot_i,
    output stats_reg_pkg::status_resp_t   status_resp_o,
    output logic [`STAT_W-1:0]            ctrl_o
);
    import stats_reg_pkg::*;

    logic               rd_q;
    logic               wr_q;
    status_addr_t       addr_q;
    logic [`STAT_W-1:0] wdata_q;
    logic               sel_hit;
    logic [`STAT_W-1:0] rd_word;
    logic               resp_valid_q;
    logic [`STAT_W-1:0] resp_data_q;
    logic [`STAT_W-1:0] ctrl_q;

    // request stage
    always_ff @(posedge clk_status) begin
        if (rst) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else begin
            rd_q <= status_req_i.read;
            wr_q <= status_req_i.write;
        end
    end

    always_ff @(posedge clk_status) begin
        addr_q  <= status_req_i.addr;
        wdata_q <= status_req_i.writedata;
    end

    assign sel_hit = (addr_q.sel == `TOP_SEL);

    always_comb begin
        case (addr_q.ofs)
            REG_IN_PKT:          rd_word = snapshot_i.evt.in_pkt;
            REG_OUT_PKT:         rd_word = snapshot_i.evt.out_pkt;
            REG_DMA_PKT:         rd_word = snapshot_i.evt.dma_pkt;
            REG_CPU_NOMATCH_PKT: rd_word = snapshot_i.evt.cpu_nomatch_pkt;
            REG_CPU_MATCH_PKT:   rd_word = snapshot_i.evt.cpu_match_pkt;
            REG_CTRL:            rd_word = ctrl_q;
            REG_MAX_DM2SM:       rd_word = snapshot_i.peak[0];
            REG_MAX_SM2PG:       rd_word = snapshot_i.peak[1];
            REG_MAX_PG2NF:       rd_word = snapshot_i.peak[2];
            REG_MAX_NF2PDU:      rd_word = snapshot_i.peak[3];
            default:             rd_word = `STAT_BAD_WORD;
        endcase
    end

    // response stage, reads for other blocks stay silent
    always_ff @(posedge clk_status) begin
        if (rst) begin
            resp_valid_q <= 1'b0;
            ctrl_q       <= '0;
        end else begin
            resp_valid_q <= rd_q & sel_hit;
            // any write to a non-ctrl offset clears ctrl
            if (wr_q && sel_hit) begin
                ctrl_q <= (addr_q.ofs == REG_CTRL) ? wdata_q : '0;
            end
        end
    end

    always_ff @(posedge clk_status) begin
        if (rd_q && sel_hit) begin
            resp_data_q <= rd_word;
        end
    end

    assign status_resp_o = '{valid: resp_valid_q, readdata: resp_data_q};
    assign ctrl_o        = ctrl_q;

    // port-level latency: strobe in, answer two edges later
    resp_after_read_a: assert property (
        @(posedge clk_status) disable iff (rst)
        resp_valid_q |-> $past(status_req_i.read, 2)
    );

endmodule

// File: status_sync.sv
`timescale 1ns/10ps
`include "stats_cfg.svh"

module status_sync #(
    parameter int STAGES = `SYNC_STAGES
) (
    input  logic                          clk_status,
    input  stats_reg_pkg::evt_count_t     evt_count_i,
    input  stats_reg_pkg::peak_vec_t      peak_i,
    output stats_reg_pkg::stat_snapshot_t snapshot_o
);
    import stats_reg_pkg::*;

    stat_snapshot_t snap_in;
    stat_snapshot_t stage_q [STAGES];

    assign snap_in = '{evt: evt_count_i, peak: peak_i};

    // plain register ranks, values are only informational
    // a word caught mid-update settles on the next sample
    always_ff @(posedge clk_status) begin
        stage_q[0] <= snap_in;
        for (int s = 1; s < STAGES; s++) begin
            stage_q[s] <= stage_q[s-1];
        end
    end

    assign snapshot_o = stage_q[STAGES-1];

endmodule

// File: tb_stats_top.sv
`timescale 1ns/10ps
`include "stats_cfg.svh"

module tb_stats_top;
    import pkt_meta_pkg::*;
    import stats_reg_pkg::*;

    typedef enum logic [2:0] {
        STEP_INGRESS, STEP_EGRESS, STEP_READY, STEP_UPDATE,
        STEP_META, STEP_FILL, STEP_WRITE, STEP_READ
    } step_kind_e;

    // operand: mark bits, {ready, valid, action}, {ch, level} or {sel, ofs}
    typedef struct packed {
        step_kind_e  kind;
        logic [31:0] operand;
        logic [31:0] expected;
    } step_t;

    localparam int N_ROWS      = 38;
    localparam int CYCLE_LIMIT = 40 * N_ROWS + 100;

    // counter reads are checked against the model, other reads against the table
    step_t steps [N_ROWS] = '{
        '{STEP_INGRESS, 32'h5, 32'h0}, '{STEP_INGRESS, 32'h6, 32'h0},
        '{STEP_INGRESS, 32'h7, 32'h0}, '{STEP_INGRESS, 32'h1, 32'h0},
        '{STEP_READ, 32'h000, 32'h0},
        '{STEP_EGRESS, 32'h5, 32'h0}, '{STEP_READY, 32'h5, 32'h0},
        '{STEP_READY, 32'h6, 32'h0}, '{STEP_READ, 32'h001, 32'h0},
        '{STEP_META, 32'h30, 32'h0}, '{STEP_META, 32'h31, 32'h0},
        '{STEP_META, 32'h32, 32'h0}, '{STEP_META, 32'h11, 32'h0},
        '{STEP_META, 32'h20, 32'h0},
        '{STEP_READ, 32'h003, 32'h0}, '{STEP_READ, 32'h004, 32'h0},
        '{STEP_UPDATE, 32'h0, 32'h0}, '{STEP_UPDATE, 32'h1, 32'h0},
        '{STEP_READ, 32'h002, 32'h0},
        '{STEP_FILL, 32'h0000_0100, 32'h0}, '{STEP_FILL, 32'h0000_0800, 32'h0},
        '{STEP_FILL, 32'h0000_0040, 32'h0}, '{STEP_FILL, 32'h0001_ffff, 32'h0},
        '{STEP_FILL, 32'h0002_1234, 32'h0}, '{STEP_FILL, 32'h0002_0034, 32'h0},
        '{STEP_FILL, 32'h0003_0777, 32'h0},
        '{STEP_READ, 32'h006, 32'h800}, '{STEP_READ, 32'h007, 32'hffff},
        '{STEP_READ, 32'h008, 32'h1234}, '{STEP_READ, 32'h009, 32'h777},
        '{STEP_WRITE, 32'h005, 32'ha5a5_0f0f}, '{STEP_READ, 32'h005, 32'ha5a5_0f0f},
        '{STEP_WRITE, 32'h305, 32'h42}, '{STEP_READ, 32'h005, 32'ha5a5_0f0f},
        '{STEP_WRITE, 32'h003, 32'h1234}, '{STEP_READ, 32'h005, 32'h0},
        '{STEP_READ, 32'h020, 32'hdead_beef}, '{STEP_READ, 32'h100, 32'h0}
    };

    logic clk_pkt, rst_pkt, clk_status, rst;
    pkt_mark_t in_mark_i, out_mark_i;
    logic out_ready_i, rb_update_valid_i, disable_pcie_i, pcie_rb_update_valid_o;
    pdu_meta_t pdumeta_cpu_data_i;
    logic pdumeta_cpu_valid_i, pdumeta_cpu_ready_i;
    fill_vec_t fill_level_i;
    status_req_t status_req_i;
    status_resp_t status_resp_o;
    logic [`STAT_W-1:0] ctrl_o;

    integer seed;
    int cycles;
    int word_errs, strobe_errs, ctrl_errs, other_errs;
    logic [`STAT_W-1:0] m_cnt [5];
    logic [`STAT_W-1:0] m_ctrl;

    stats_top dut_i (.*);

    initial begin
        clk_status = 1'b0;
        forever #20 clk_status = ~clk_status;
    end

    initial begin
        clk_pkt = 1'b0;
        forever #15 clk_pkt = ~clk_pkt;
    end

    task automatic check_word(input status_resp_t got, input status_resp_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: pcie update strobe got %b expected %b",
                     $time, got, exp);
            strobe_errs++;
        end
    endtask

    task automatic check_ctrl(input logic [`STAT_W-1:0] got, input logic [`STAT_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: ctrl_o got %h expected %h", $time, got, exp);
            ctrl_errs++;
        end
    endtask

    task automatic run_step(input step_t st);
        int n;
        int lat;
        logic [3:0] sel;
        logic [7:0] ofs;
        status_req_t req;
        status_resp_t resp;
        status_resp_t exp_resp;
        n = ($unsigned($random(seed)) % 8) + 1;
        sel = st.operand[11:8];
        ofs = st.operand[7:0];
        req = '0;
        req.addr.sel = sel;
        req.addr.ofs = ofs;
        case (st.kind)
            STEP_INGRESS: begin
                repeat (n) begin
                    @(negedge clk_pkt);
                    in_mark_i = st.operand[2:0];
                end
                @(negedge clk_pkt);
                in_mark_i = '0;
                if (st.operand[2] && st.operand[0]) m_cnt[0] += n;
            end
            STEP_EGRESS, STEP_READY: begin
                repeat (n) begin
                    @(negedge clk_pkt);
                    out_mark_i  = st.operand[2:0];
                    out_ready_i = (st.kind == STEP_READY);
                end
                @(negedge clk_pkt);
                out_mark_i  = '0;
                out_ready_i = 1'b0;
                if (st.kind == STEP_READY && st.operand[2] && st.operand[0]) m_cnt[1] += n;
            end
            STEP_UPDATE: begin
                repeat (n) begin
                    @(negedge clk_pkt);
                    rb_update_valid_i = 1'b1;
                    disable_pcie_i    = st.operand[0];
                    #1 check_strobe(pcie_rb_update_valid_o, !st.operand[0]);
                end
                @(negedge clk_pkt);
                rb_update_valid_i = 1'b0;
                disable_pcie_i    = 1'b0;
                #1 check_strobe(pcie_rb_update_valid_o, 1'b0);
                m_cnt[2] += n;
            end
            STEP_META: begin
                repeat (n) begin
                    @(negedge clk_pkt);
                    pdumeta_cpu_data_i.action = pdu_action_e'(st.operand[3:0]);
                    pdumeta_cpu_data_i.tag    = 24'(n);
                    pdumeta_cpu_valid_i       = st.operand[4];
                    pdumeta_cpu_ready_i       = st.operand[5];
                end
                @(negedge clk_pkt);
                pdumeta_cpu_valid_i = 1'b0;
                pdumeta_cpu_ready_i = 1'b0;
                if (st.operand[4] && st.operand[5] && st.operand[3:0] == 4'd0) m_cnt[3] += n;
                if (st.operand[4] && st.operand[5] && st.operand[3:0] == 4'd1) m_cnt[4] += n;
            end
            STEP_FILL: begin
                @(negedge clk_pkt);
                fill_level_i[st.operand[17:16]] = st.operand[15:0];
                @(negedge clk_pkt);
            end
            STEP_WRITE: begin
                @(negedge clk_status);
                req.write     = 1'b1;
                req.writedata = st.expected;
                status_req_i  = req;
                @(negedge clk_status);
                status_req_i = '0;
                @(negedge clk_status);
                if (sel == `TOP_SEL) m_ctrl = (ofs == REG_CTRL) ? st.expected : '0;
                check_ctrl(ctrl_o, m_ctrl);
            end
            default: begin
                // let the counters cross into clk_status
                repeat (10) @(negedge clk_status);
                req.read     = 1'b1;
                status_req_i = req;
                @(negedge clk_status);
                status_req_i = '0;
                lat  = 0;
                resp = '0;
                for (int i = 1; i <= 6 && lat == 0; i++) begin
                    if (status_resp_o.valid) begin
                        lat  = i;
                        resp = status_resp_o;
                    end else begin
                        @(negedge clk_status);
                    end
                end
                exp_resp.valid    = 1'b1;
                exp_resp.readdata = (ofs <= REG_CPU_MATCH_PKT) ? m_cnt[ofs] : st.expected;
                if (sel != `TOP_SEL && lat != 0) begin
                    $display("read with select %0h got a response it should not", sel);
                    other_errs++;
                end else if (sel == `TOP_SEL && lat != 2) begin
                    $display("read of offset %0h answered after %0d cycles, not 2", ofs, lat);
                    other_errs++;
                end else if (sel == `TOP_SEL) begin
                    check_word(resp, exp_resp, $sformatf("read of offset %0h", ofs));
                end
            end
        endcase
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_status);
            cycles++;
        end
        $display("timeout: run still busy after %0d status cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed = 32'hefb1_e29c;
        rst = 1'b1;
        rst_pkt = 1'b1;
        in_mark_i = '0;
        out_mark_i = '0;
        out_ready_i = 1'b0;
        rb_update_valid_i = 1'b0;
        disable_pcie_i = 1'b0;
        pdumeta_cpu_data_i = '0;
        pdumeta_cpu_valid_i = 1'b0;
        pdumeta_cpu_ready_i = 1'b0;
        fill_level_i = '0;
        status_req_i = '0;
        m_ctrl = '0;
        for (int k = 0; k < 5; k++) m_cnt[k] = '0;
        fork
            begin
                repeat (4) @(negedge clk_status);
                rst = 1'b0;
            end
            begin
                repeat (4) @(negedge clk_pkt);
                rst_pkt = 1'b0;
            end
        join
        for (int r = 0; r < N_ROWS; r++) run_step(steps[r]);
        $display("errors: read data %0d, strobe %0d, ctrl %0d, protocol %0d",
                 word_errs, strobe_errs, ctrl_errs, other_errs);
        if (word_errs + strobe_errs + ctrl_errs + other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
